// ==== flist.f ====
+incdir+.
s16_bus_pkg.sv
s16_credit_fifo.sv
s16_bus_decode.sv
s16_bus_execute.sv
s16_bus_result.sv
s16_bus_top.sv
s16_bus_chk.sv
s16_bus_tb.sv

// ==== s16_bus_chk.sv ====
// Concurrent checks on the credit and handshake rules, bound into the bus top level
`include "s16_consts.svh"

module s16_bus_chk (
    input clk,
    input rst_n,
    input req_valid,
    input req_credit,
    input rsp_valid,
    input rsp_credit
);

logic [7:0] rsp_held;
logic [3:0] req_out;
int         fails = 0;

// Independent copies of both credit balances
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        rsp_held <= '0;
        req_out  <= '0;
    end else begin
        rsp_held <= rsp_held + rsp_credit - rsp_valid;
        req_out  <= req_out + req_valid - req_credit;
    end
end

rsp_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> rsp_held != '0)
    else begin
        $error("response sent without a consumer credit");
        fails++;
    end

req_within_credit: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid |-> req_out < `S16_REQ_CREDITS)
    else begin
        $error("more requests outstanding than request credits");
        fails++;
    end

outputs_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({rsp_valid, req_credit}))
    else begin
        $error("rsp_valid or req_credit unknown after reset");
        fails++;
    end

endmodule

bind s16_bus_top s16_bus_chk chk_i (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .req_valid  ( req_valid  ),
    .req_credit ( req_credit ),
    .rsp_valid  ( rsp_valid  ),
    .rsp_credit ( rsp_credit )
);

// ==== s16_bus_decode.sv ====
// First pipeline stage, maps a bus address to a memory region and the word offset in it
`include "s16_consts.svh"

module s16_bus_decode import s16_bus_pkg::*; (
    input                clk,
    input                rst_n,
    input                in_valid,
    input  s16_bus_req_t in_req,
    output logic         in_ready,
    input                stall,
    output logic         out_valid,
    output s16_dec_req_t out_dec
);

localparam int AW    = `S16_ADDR_W;
localparam int OFF_W = `S16_OFF_W;

s16_region_e dec_region;
logic [AW-1:0] dec_base;
logic [AW-1:0] dec_off;

function automatic logic hit(input logic [AW-1:0] addr, input int base, input int words);
    return (int'(addr) >= base) && (int'(addr) < base + words);
endfunction

assign in_ready = !stall;

always_comb begin
    dec_region = rgn_none;
    dec_base   = '0;
    if (hit(in_req.addr, `S16_CHAR_BASE, `S16_CHAR_WORDS)) begin
        dec_region = rgn_char;
        dec_base   = AW'(`S16_CHAR_BASE);
    end else if (hit(in_req.addr, `S16_OBJ_BASE, `S16_OBJ_WORDS)) begin
        dec_region = rgn_obj;
        dec_base   = AW'(`S16_OBJ_BASE);
    end else if (hit(in_req.addr, `S16_PAL_BASE, `S16_PAL_WORDS)) begin
        dec_region = rgn_pal;
        dec_base   = AW'(`S16_PAL_BASE);
    end else if (hit(in_req.addr, `S16_RAM_BASE, `S16_RAM_WORDS)) begin
        dec_region = rgn_ram;
        dec_base   = AW'(`S16_RAM_BASE);
    end else if (hit(in_req.addr, `S16_IO_BASE, `S16_IO_WORDS)) begin
        dec_region = rgn_io;
        dec_base   = AW'(`S16_IO_BASE);
    end
end

// Unmapped cycles keep base 0, offset is ignored downstream
assign dec_off = in_req.addr - dec_base;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        out_valid <= 1'b0;
    end else if (!stall) begin
        out_valid <= in_valid;
    end
end

always_ff @(posedge clk) begin
    if (!stall) begin
        out_dec.req    <= in_req;
        out_dec.region <= dec_region;
        out_dec.offset <= dec_off[OFF_W-1:0];
    end
end

endmodule

// ==== s16_bus_execute.sv ====
// Second pipeline stage, holds the video and work RAMs plus the cabinet port and performs the access
`include "s16_consts.svh"

module s16_bus_execute import s16_bus_pkg::*; (
    input                clk,
    input                rst_n,
    input                in_valid,
    input  s16_dec_req_t in_dec,
    input                stall,
    input        [7:0]   joystick1,
    input        [7:0]   joystick2,
    input        [1:0]   start_button,
    input        [1:0]   coin_input,
    output logic         out_valid,
    output s16_exe_t     out_exe
);

localparam int DW      = `S16_DATA_W;
localparam int CHAR_AW = $clog2(`S16_CHAR_WORDS);
localparam int OBJ_AW  = $clog2(`S16_OBJ_WORDS);
localparam int PAL_AW  = $clog2(`S16_PAL_WORDS);
localparam int RAM_AW  = $clog2(`S16_RAM_WORDS);

logic [DW-1:0] char_ram [`S16_CHAR_WORDS];
logic [DW-1:0] obj_ram  [`S16_OBJ_WORDS];
logic [DW-1:0] pal_ram  [`S16_PAL_WORDS];
logic [DW-1:0] work_ram [`S16_RAM_WORDS];

logic [CHAR_AW-1:0] char_a;
logic [OBJ_AW-1:0]  obj_a;
logic [PAL_AW-1:0]  pal_a;
logic [RAM_AW-1:0]  ram_a;
logic [DW-1:0]      wd;
logic [DW-1:0]      rd_word;
logic [1:0]         lane_we;
logic               wr_en;

assign char_a  = in_dec.offset[CHAR_AW-1:0];
assign obj_a   = in_dec.offset[OBJ_AW-1:0];
assign pal_a   = in_dec.offset[PAL_AW-1:0];
assign ram_a   = in_dec.offset[RAM_AW-1:0];
assign wd      = in_dec.req.wdata;
// dsn low enables a lane
assign lane_we = ~in_dec.req.dsn;
assign wr_en   = in_valid && !stall && !in_dec.req.rnw;

// Byte-masked writes, only the decoded region is touched
always_ff @(posedge clk) begin
    if (wr_en) begin
        case (in_dec.region)
            rgn_char: begin
                if (lane_we[1]) char_ram[char_a][15:8] <= wd[15:8];
                if (lane_we[0]) char_ram[char_a][7:0]  <= wd[7:0];
            end
            rgn_obj: begin
                if (lane_we[1]) obj_ram[obj_a][15:8] <= wd[15:8];
                if (lane_we[0]) obj_ram[obj_a][7:0]  <= wd[7:0];
            end
            rgn_pal: begin
                if (lane_we[1]) pal_ram[pal_a][15:8] <= wd[15:8];
                if (lane_we[0]) pal_ram[pal_a][7:0]  <= wd[7:0];
            end
            rgn_ram: begin
                if (lane_we[1]) work_ram[ram_a][15:8] <= wd[15:8];
                if (lane_we[0]) work_ram[ram_a][7:0]  <= wd[7:0];
            end
            default: ;  // port writes are acknowledged only
        endcase
    end
end

// Read mux ahead of the output register
always_comb begin
    case (in_dec.region)
        rgn_char: rd_word = char_ram[char_a];
        rgn_obj:  rd_word = obj_ram[obj_a];
        rgn_pal:  rd_word = pal_ram[pal_a];
        rgn_ram:  rd_word = work_ram[ram_a];
        rgn_io:   rd_word = in_dec.offset[0] ? {12'h000, coin_input, start_button}
                                             : {joystick2, joystick1};
        default:  rd_word = '0;
    endcase
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        out_valid <= 1'b0;
    end else if (!stall) begin
        out_valid <= in_valid;
    end
end

always_ff @(posedge clk) begin
    if (!stall) begin
        out_exe.rdata <= rd_word;
        out_exe.err   <= in_dec.region == rgn_none;
        out_exe.rnw   <= in_dec.req.rnw;
    end
end

endmodule

// ==== s16_bus_pkg.sv ====
// Bus cycle, decode and response types shared by every stage of the main-CPU bus model
`include "s16_consts.svh"

package s16_bus_pkg;

    // Target of a bus cycle after address decode
    typedef enum logic [2:0] {
        rgn_char = 3'd0,
        rgn_obj  = 3'd1,
        rgn_pal  = 3'd2,
        rgn_ram  = 3'd3,
        rgn_io   = 3'd4,
        rgn_none = 3'd7
    } s16_region_e;

    // CPU bus cycle as it enters the request queue
    typedef struct packed {
        logic [`S16_ADDR_W-1:0] addr;
        logic [`S16_DATA_W-1:0] wdata;
        logic [1:0]             dsn;    // upper, lower byte, active low
        logic                   rnw;
    } s16_bus_req_t;

    // Decode to execute
    typedef struct packed {
        s16_bus_req_t          req;
        s16_region_e           region;
        logic [`S16_OFF_W-1:0] offset;
    } s16_dec_req_t;

    // Execute to result
    typedef struct packed {
        logic [`S16_DATA_W-1:0] rdata;
        logic                   err;
        logic                   rnw;
    } s16_exe_t;

    // Response returned to the consumer
    typedef struct packed {
        logic [`S16_DATA_W-1:0] rdata;
        logic                   err;
        logic                   was_write;
    } s16_bus_rsp_t;

endpackage

// ==== s16_bus_result.sv ====
// Last pipeline stage, formats responses and stalls the pipe when the response queue has no room
`include "s16_consts.svh"

module s16_bus_result import s16_bus_pkg::*; (
    input                clk,
    input                rst_n,
    input                in_valid,
    input  s16_exe_t     in_exe,
    input                rsp_space,  // one slot freed in the response queue
    output logic         stall,
    output logic         push,
    output s16_bus_rsp_t push_rsp
);

localparam int SPACE_W = $clog2(`S16_RSP_CREDITS + 1);

// Free response slots, an accepted entry counts as used at once
logic [SPACE_W-1:0] space;
logic               take;

assign stall = space == '0;
assign take  = in_valid && !stall;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        space <= SPACE_W'(`S16_RSP_CREDITS);
        push  <= 1'b0;
    end else begin
        space <= space - SPACE_W'(take) + SPACE_W'(rsp_space);
        push  <= take;
    end
end

// Writes and bus errors return zero data
always_ff @(posedge clk) begin
    if (take) begin
        push_rsp.rdata     <= (in_exe.rnw && !in_exe.err) ? in_exe.rdata : '0;
        push_rsp.err       <= in_exe.err;
        push_rsp.was_write <= !in_exe.rnw;
    end
end

endmodule

// ==== s16_bus_tb.sv ====
// Testbench for the bus subsystem, replays the test data file under request and response credits
`include "s16_consts.svh"

module s16_bus_tb import s16_bus_pkg::*; ();

localparam int TIMEOUT = 2000;

logic         clk, rst_n, req_valid, req_credit, rsp_valid, rsp_credit;
s16_bus_req_t req;
s16_bus_rsp_t rsp;
logic [7:0]   joystick1, joystick2;
logic [1:0]   start_button, coin_input;

s16_bus_rsp_t exp_rsp [$];
string        exp_name [$];
logic [15:0]  model [int];
int           issued = 0, returned = 0, sent = 0, grants = 0, tests = 0, errors = 0;
logic         grant_en = 1'b1;
logic         grant_next = 1'b0;

s16_bus_top dut_i (.*);

always #2 clk = ~clk;

// Response check and consumer credit decision, sampled on the rising edge
always @(posedge clk) begin : monitor
    s16_bus_rsp_t e;
    string        nm;
    if (rst_n) begin
        sent     += int'(req_valid);
        returned += int'(req_credit);
        grants   += int'(rsp_credit);
        if (rsp_valid) begin
            assert (exp_rsp.size() != 0)
            else begin
                $display("ERROR: response arrived with no request outstanding");
                errors++;
            end
        end
        if (rsp_valid && exp_rsp.size() != 0) begin
            e  = exp_rsp.pop_front();
            nm = exp_name.pop_front();
            tests++;
            assert (rsp === e) $display("[PASS] %s", nm);
            else begin
                $display("[FAIL] %s expected rdata=%h err=%b wr=%b actual rdata=%h err=%b wr=%b",
                         nm, e.rdata, e.err, e.was_write, rsp.rdata, rsp.err, rsp.was_write);
                errors++;
            end
        end
        // Grant only for requests already issued
        grant_next = grant_en && grants < sent && $urandom_range(0, 2) == 0;
    end
end

always @(negedge clk) begin
    rsp_credit <= grant_next;
end

task automatic stop_on_timeout(input string what);
    $display("ERROR: timed out waiting for %s", what);
    $display("%0d tests, %0d failed", tests, errors + 1);
    $display("SOME TESTS FAILED");
    $finish;
endtask

function automatic logic is_ram(input int a);
    return (a >= `S16_CHAR_BASE && a < `S16_CHAR_BASE + `S16_CHAR_WORDS) ||
           (a >= `S16_OBJ_BASE && a < `S16_OBJ_BASE + `S16_OBJ_WORDS) ||
           (a >= `S16_PAL_BASE && a < `S16_PAL_BASE + `S16_PAL_WORDS) ||
           (a >= `S16_RAM_BASE && a < `S16_RAM_BASE + `S16_RAM_WORDS);
endfunction

// Reference memory, a high dsn bit keeps the old byte
task automatic model_write(input int a, input logic [15:0] d, input logic [1:0] dsn);
    logic [15:0] w;
    w = model.exists(a) ? model[a] : 16'h0000;
    if (!dsn[1]) w[15:8] = d[15:8];
    if (!dsn[0]) w[7:0] = d[7:0];
    if (is_ram(a)) model[a] = w;
endtask

task automatic send(input string nm, input s16_bus_req_t r, input s16_bus_rsp_t e, input int gap);
    int t;
    t = 0;
    while (`S16_REQ_CREDITS - issued + returned == 0) begin
        @(negedge clk);
        t++;
        if (t > TIMEOUT) stop_on_timeout("a request credit");
    end
    req       = r;
    req_valid = 1'b1;
    issued++;
    exp_rsp.push_back(e);
    exp_name.push_back(nm);
    @(negedge clk);
    req_valid = 1'b0;
    repeat (gap) @(negedge clk);
endtask

task automatic drain();
    int t;
    t = 0;
    while (exp_rsp.size() != 0) begin
        @(negedge clk);
        t++;
        if (t > TIMEOUT) stop_on_timeout("outstanding responses");
    end
endtask

initial begin : stimulus
    int           fd, n, a, cnt;
    string        nm, op, line;
    logic [15:0]  addr, data, exp_d;
    logic [1:0]   dsn;
    logic         exp_e;
    s16_bus_req_t r;
    s16_bus_rsp_t e;
    clk          = 1'b0;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    rsp_credit   = 1'b0;
    joystick1    = 8'h5a;
    joystick2    = 8'hc3;
    start_button = 2'b10;
    coin_input   = 2'b01;
    void'($urandom(78453));
    fd = $fopen("s16_bus_testdata.txt", "r");
    if (fd == 0) begin
        $display("ERROR: cannot open the test data file");
        $display("SOME TESTS FAILED");
        $finish;
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    while ($fscanf(fd, "%s", nm) == 1) begin
        if (nm.substr(0, 0) == "#") begin
            void'($fgets(line, fd));
            continue;
        end
        n = $fscanf(fd, "%s %h %h %b %h %h", op, addr, data, dsn, exp_d, exp_e);
        if (n != 6) begin
            $display("ERROR: malformed data line for test %s", nm);
            errors++;
            break;
        end
        if (op == "P" || op == "B") begin
            // P fills the response queue with no consumer credits, B is a random burst
            drain();
            grant_en = op != "P";
            cnt = (op == "P") ? `S16_REQ_CREDITS + 4 : int'(data);
            for (int i = 0; i < cnt; i++) begin
                if (op == "P") begin
                    a       = addr + i / 2;
                    r.wdata = data + 16'(i);
                    r.dsn   = 2'b00;
                    r.rnw   = i % 2;
                end else begin
                    case ($urandom_range(0, 3))
                        0:       a = `S16_CHAR_BASE;
                        1:       a = `S16_OBJ_BASE;
                        2:       a = `S16_PAL_BASE;
                        default: a = `S16_RAM_BASE;
                    endcase
                    a       += $urandom_range(0, 7);
                    r.wdata = 16'($urandom);
                    r.dsn   = model.exists(a) ? 2'($urandom_range(0, 2)) : 2'b00;
                    r.rnw   = model.exists(a) && $urandom_range(0, 1) == 1;
                end
                r.addr = 14'(a);
                e = r.rnw ? {model[a], 2'b00} : {16'h0000, 2'b01};
                if (!r.rnw) model_write(a, r.wdata, r.dsn);
                send($sformatf("%s_%0d", nm, i), r, e, (op == "P") ? $urandom_range(0, 1) : 0);
            end
            grant_en = 1'b1;
        end else begin
            r = {addr[13:0], data, dsn, op == "R"};
            e = {exp_d, exp_e, op == "W"};
            if (op == "W") model_write(int'(addr), data, dsn);
            send(nm, r, e, $urandom_range(0, 2));
        end
    end
    $fclose(fd);
    drain();
    tests++;
    assert (returned == issued) $display("[PASS] req_credit_total");
    else begin
        $display("[FAIL] req_credit_total expected %0d actual %0d", issued, returned);
        errors++;
    end
    errors += dut_i.chk_i.fails;
    $display("%0d tests, %0d failed", tests, errors);
    if (errors == 0) begin
        $display("ALL TESTS PASSED");
    end else begin
        $display("SOME TESTS FAILED");
    end
    $finish;
end

endmodule

// ==== s16_bus_testdata.txt ====
# Columns: test name, op (W write, R read, P back-pressure, B random burst),
# address, write data (P start value, B cycle count), dsn, expected rdata, expected err
char_wr    W 0005 1234 00 0000 0
obj_wr     W 0805 abcd 00 0000 0
pal_wr     W 1005 5566 00 0000 0
ram_wr     W 2005 7788 00 0000 0
char_rd    R 0005 0000 11 1234 0
obj_rd     R 0805 0000 11 abcd 0
pal_rd     R 1005 0000 11 5566 0
ram_rd     R 2005 0000 11 7788 0
lane_init  W 2010 ffff 00 0000 0
lane_lo    W 2010 0012 10 0000 0
lane_lo_rd R 2010 0000 11 ff12 0
lane_hi    W 2010 3400 01 0000 0
lane_hi_rd R 2010 0000 11 3412 0
char0_wr   W 0000 1111 00 0000 0
ram0_wr    W 2000 2222 00 0000 0
unmap_wr   W 1800 dead 00 0000 1
unmap_rd   R 1800 0000 11 0000 1
char0_rd   R 0000 0000 11 1111 0
ram0_rd    R 2000 0000 11 2222 0
io_hole    R 3002 0000 11 0000 1
io_joy     R 3000 0000 11 c35a 0
io_btn     R 3001 0000 11 0006 0
io_wr      W 3000 ffff 00 0000 0
io_joy_rd  R 3000 0000 11 c35a 0
backpress  P 2100 0500 00 0000 0
burst      B 0000 0030 00 0000 0

// ==== s16_bus_top.sv ====
// Main-CPU bus subsystem, credit-controlled request and response channels around a 3-stage pipe
`include "s16_consts.svh"

module s16_bus_top import s16_bus_pkg::*; (
    input                clk,
    input                rst_n,
    // Request channel
    input                req_valid,
    input  s16_bus_req_t req,
    output logic         req_credit,
    // Response channel
    output logic         rsp_valid,
    output s16_bus_rsp_t rsp,
    input                rsp_credit,
    // Cabinet inputs
    input        [7:0]   joystick1,
    input        [7:0]   joystick2,
    input        [1:0]   start_button,
    input        [1:0]   coin_input
);

localparam int CRED_W = `S16_CRED_W;

s16_bus_req_t    fifo_req;
logic            fifo_req_valid, dec_ready;
s16_dec_req_t    dec_out;
logic            dec_valid;
s16_exe_t        exe_out;
logic            exe_valid;
logic            stall;
logic            res_push;
s16_bus_rsp_t    res_rsp;
logic            rsp_slot_free;
logic            rsp_pop_valid;
logic [CRED_W-1:0] rsp_cred_cnt;
logic            rsp_have_cred;

s16_credit_fifo #(
    .T          ( s16_bus_req_t    ),
    .DEPTH      ( `S16_REQ_CREDITS )
) u_req_fifo (
    .clk        ( clk            ),
    .rst_n      ( rst_n          ),
    .push       ( req_valid      ),
    .push_data  ( req            ),
    .pop_ready  ( dec_ready      ),
    .pop_valid  ( fifo_req_valid ),
    .pop_data   ( fifo_req       ),
    .credit     ( req_credit     )
);

s16_bus_decode u_decode (
    .clk        ( clk            ),
    .rst_n      ( rst_n          ),
    .in_valid   ( fifo_req_valid ),
    .in_req     ( fifo_req       ),
    .in_ready   ( dec_ready      ),
    .stall      ( stall          ),
    .out_valid  ( dec_valid      ),
    .out_dec    ( dec_out        )
);

s16_bus_execute u_execute (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .in_valid     ( dec_valid    ),
    .in_dec       ( dec_out      ),
    .stall        ( stall        ),
    .joystick1    ( joystick1    ),
    .joystick2    ( joystick2    ),
    .start_button ( start_button ),
    .coin_input   ( coin_input   ),
    .out_valid    ( exe_valid    ),
    .out_exe      ( exe_out      )
);

s16_bus_result u_result (
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .in_valid   ( exe_valid     ),
    .in_exe     ( exe_out       ),
    .rsp_space  ( rsp_slot_free ),
    .stall      ( stall         ),
    .push       ( res_push      ),
    .push_rsp   ( res_rsp       )
);

s16_credit_fifo #(
    .T          ( s16_bus_rsp_t    ),
    .DEPTH      ( `S16_RSP_CREDITS )
) u_rsp_fifo (
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .push       ( res_push      ),
    .push_data  ( res_rsp       ),
    .pop_ready  ( rsp_have_cred ),
    .pop_valid  ( rsp_pop_valid ),
    .pop_data   ( rsp           ),
    .credit     ( rsp_slot_free )
);

// Consumer credits gate every response
assign rsp_have_cred = rsp_cred_cnt != '0;
assign rsp_valid     = rsp_pop_valid && rsp_have_cred;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        rsp_cred_cnt <= '0;
    end else begin
        rsp_cred_cnt <= rsp_cred_cnt + CRED_W'(rsp_credit) - CRED_W'(rsp_valid);
    end
end

endmodule

// ==== s16_consts.svh ====
// Bus map and credit sizes, included by the package, the RTL stages and the testbench
`ifndef S16_CONSTS_SVH
`define S16_CONSTS_SVH

// Word addressing on the CPU side
`define S16_ADDR_W      14
`define S16_DATA_W      16
`define S16_OFF_W       11

// Character (tile) RAM
`define S16_CHAR_BASE   'h0000
`define S16_CHAR_WORDS  2048
// Object (sprite) RAM
`define S16_OBJ_BASE    'h0800
`define S16_OBJ_WORDS   256
// Palette RAM
`define S16_PAL_BASE    'h1000
`define S16_PAL_WORDS   1024
// Work RAM
`define S16_RAM_BASE    'h2000
`define S16_RAM_WORDS   2048
// Cabinet inputs, word 0 joysticks and word 1 start/coin
`define S16_IO_BASE     'h3000
`define S16_IO_WORDS    2

// Flow control
`define S16_REQ_CREDITS 4
`define S16_RSP_CREDITS 4
// Consumer credits held by the top level
`define S16_CRED_W      8

`endif

// ==== s16_credit_fifo.sv ====
// Circular queue for any payload type, returning one credit pulse per popped entry
module s16_credit_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input        clk,
    input        rst_n,
    input        push,
    input  T     push_data,
    input        pop_ready,
    output logic pop_valid,
    output T     pop_data,
    output logic credit
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

T                 mem [DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;
logic             pop;

// Wraps at DEPTH, which need not be a power of two
function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
endfunction

assign pop_valid = count != '0;
assign pop       = pop_valid && pop_ready;
assign pop_data  = mem[rd_ptr];

// Storage
always_ff @(posedge clk) begin
    if (push) begin
        mem[wr_ptr] <= push_data;
    end
end

// The sender holds credits, so no push arrives while full
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
        credit <= 1'b0;
    end else begin
        if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
        end
        if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
        end
        count  <= count + CNT_W'(push) - CNT_W'(pop);
        // Slot handed back one cycle after the pop
        credit <= pop;
    end
end

endmodule
